/* apb_soc_macros.svh */
/*
 * Widths, window map and counter size of the APB peripheral subsystem.
 * Each window must be a power of two in size and aligned to that size.
 */

`ifndef APB_SOC_MACROS_SVH
`define APB_SOC_MACROS_SVH

// ----------------------------------------------------------------------
// Bus widths
// ----------------------------------------------------------------------
`define APB_SOC_ADDR_W      32
`define APB_SOC_DATA_W      32

// GPIO pin count, no wider than the data word
`define APB_SOC_NUM_GPIO    32

// ----------------------------------------------------------------------
// Peripheral windows
// ----------------------------------------------------------------------
`define APB_SOC_GPIO_BASE   32'h1A10_1000
`define APB_SOC_CTRL_BASE   32'h1A10_4000
// 4 KiB per window
`define APB_SOC_WIN_SIZE    32'h0000_1000

// Last-level-cache event counters wrap at this width
`define APB_SOC_CNT_W       32

`endif

/* apb_soc_pkg.sv */
/*
 * Bus-level types shared by the APB interface, the decoder and the top.
 * Widths come from the macro header.
 */

`include "apb_soc_macros.svh"

package apb_soc_pkg;

   // ----------------------------------------------------------------------
   // APB words
   // ----------------------------------------------------------------------
   typedef logic [`APB_SOC_ADDR_W-1:0] apb_addr_t;
   typedef logic [`APB_SOC_DATA_W-1:0] apb_data_t;

   // Result of the address decode
   typedef enum logic [1:0] {
      TGT_NONE = 2'd0,
      TGT_GPIO = 2'd1,
      TGT_CTRL = 2'd2
   } apb_target_e;

endpackage

/* periph_regs_pkg.sv */
/*
 * Register-level types of the GPIO and SoC control blocks.
 * Offsets are relative to the start of each window.
 */

`include "apb_soc_macros.svh"

package periph_regs_pkg;

   // Offset inside one peripheral window
   typedef logic [$clog2(`APB_SOC_WIN_SIZE)-1:0] reg_off_t;

   // ----------------------------------------------------------------------
   // Register maps
   // ----------------------------------------------------------------------
   typedef enum reg_off_t {
      GPIO_DIR  = 'h000,
      GPIO_OUT  = 'h004,
      GPIO_IN   = 'h008,
      GPIO_RISE = 'h00C
   } gpio_reg_e;

   typedef enum reg_off_t {
      CTRL_CLUSTER    = 'h000,
      CTRL_READ_HIT   = 'h010,
      CTRL_READ_MISS  = 'h014,
      CTRL_WRITE_HIT  = 'h018,
      CTRL_WRITE_MISS = 'h01C
   } ctrl_reg_e;

   // One flag per cache event, read_hit in bit 0
   typedef struct packed {
      logic write_miss;
      logic write_hit;
      logic read_miss;
      logic read_hit;
   } llc_events_t;

   // Cluster control, rstn in bit 0
   typedef struct packed {
      logic fetch_en;
      logic en_sa_boot;
      logic rstn;
   } cluster_ctrl_t;

endpackage

/* apb_if.sv */
/*
 * APB link between the decoder and one peripheral.
 * No wait states are used inside the subsystem.
 */

interface apb_if;

   import apb_soc_pkg::*;

   logic      psel;
   logic      penable;
   logic      pwrite;
   apb_addr_t paddr;
   apb_data_t pwdata;
   apb_data_t prdata;
   logic      pready;
   logic      pslverr;

   modport master (
      output psel, penable, pwrite, paddr, pwdata,
      input  prdata, pready, pslverr
   );

   modport slave (
      input  psel, penable, pwrite, paddr, pwdata,
      output prdata, pready, pslverr
   );

endinterface

/* edge_sync.sv */
/*
 * Two-flop synchronizer with rising-edge detect, any packed payload.
 * Each bit is synchronized on its own; multi-bit values are not coherent.
 */

module edge_sync #(
   parameter type T_PAYLOAD = logic
) (
   input  logic     clk_i,
   input  logic     rst_i,
   input  T_PAYLOAD async_i,
   output T_PAYLOAD level_o,
   output T_PAYLOAD rise_o
);

   localparam int unsigned W = $bits(T_PAYLOAD);

   logic [W-1:0] meta_q;
   logic [W-1:0] level_q;
   logic [W-1:0] prev_q;

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         meta_q  <= '0;
         level_q <= '0;
         prev_q  <= '0;
      end else begin
         meta_q  <= async_i;
         level_q <= meta_q;
         // Previous synchronized value for the edge compare
         prev_q  <= level_q;
      end
   end

   assign level_o = T_PAYLOAD'(level_q);
   assign rise_o  = T_PAYLOAD'(level_q & ~prev_q);

endmodule

/* apb_periph_demux.sv */
/*
 * Combinational APB decoder for the GPIO and SoC control windows.
 * Unmapped addresses are answered here with an error in the first access cycle.
 */

`include "apb_soc_macros.svh"

module apb_periph_demux (
   input  logic                  psel_i,
   input  logic                  penable_i,
   input  logic                  pwrite_i,
   input  apb_soc_pkg::apb_addr_t paddr_i,
   input  apb_soc_pkg::apb_data_t pwdata_i,
   output apb_soc_pkg::apb_data_t prdata_o,
   output logic                  pready_o,
   output logic                  pslverr_o,
   apb_if.master                 gpio_m,
   apb_if.master                 ctrl_m
);

   import apb_soc_pkg::*;

   localparam apb_addr_t GPIO_BASE = `APB_SOC_GPIO_BASE;
   localparam apb_addr_t CTRL_BASE = `APB_SOC_CTRL_BASE;
   localparam apb_addr_t WIN_SIZE  = `APB_SOC_WIN_SIZE;

   apb_target_e target;

   // ----------------------------------------------------------------------
   // Address decode
   // ----------------------------------------------------------------------
   always_comb begin
      // Unsigned difference covers both window bounds at once
      if (apb_addr_t'(paddr_i - GPIO_BASE) < WIN_SIZE) begin
         target = TGT_GPIO;
      end else if (apb_addr_t'(paddr_i - CTRL_BASE) < WIN_SIZE) begin
         target = TGT_CTRL;
      end else begin
         target = TGT_NONE;
      end
   end

   // ----------------------------------------------------------------------
   // Request fan-out
   // ----------------------------------------------------------------------
   assign gpio_m.psel    = psel_i && (target == TGT_GPIO);
   assign gpio_m.penable = penable_i;
   assign gpio_m.pwrite  = pwrite_i;
   assign gpio_m.paddr   = paddr_i;
   assign gpio_m.pwdata  = pwdata_i;

   assign ctrl_m.psel    = psel_i && (target == TGT_CTRL);
   assign ctrl_m.penable = penable_i;
   assign ctrl_m.pwrite  = pwrite_i;
   assign ctrl_m.paddr   = paddr_i;
   assign ctrl_m.pwdata  = pwdata_i;

   // ----------------------------------------------------------------------
   // Response combine
   // ----------------------------------------------------------------------
   always_comb begin
      case (target)
         TGT_GPIO: begin
            prdata_o  = gpio_m.prdata;
            pready_o  = gpio_m.pready;
            pslverr_o = gpio_m.pslverr;
         end
         TGT_CTRL: begin
            prdata_o  = ctrl_m.prdata;
            pready_o  = ctrl_m.pready;
            pslverr_o = ctrl_m.pslverr;
         end
         default: begin
            // Nothing mapped here, finish at once with an error
            prdata_o  = '0;
            pready_o  = psel_i && penable_i;
            pslverr_o = psel_i && penable_i;
         end
      endcase
   end

endmodule

/* apb_gpio.sv */
/*
 * GPIO block: direction, output, synchronized input and sticky rise status.
 * RISE bits clear on write-one; a new edge in the same cycle keeps the bit set.
 */

`include "apb_soc_macros.svh"

module apb_gpio (
   input  logic                         clk_i,
   input  logic                         rst_i,
   apb_if.slave                         bus_s,
   input  logic [`APB_SOC_NUM_GPIO-1:0] gpio_i,
   output logic [`APB_SOC_NUM_GPIO-1:0] gpio_out_o,
   output logic [`APB_SOC_NUM_GPIO-1:0] gpio_dir_o,
   output logic                         gpio_irq_o
);

   import apb_soc_pkg::*;
   import periph_regs_pkg::*;

   typedef logic [`APB_SOC_NUM_GPIO-1:0] gpio_vec_t;

   reg_off_t  offset;
   logic      wr_en;
   gpio_vec_t wdata;
   gpio_vec_t dir_q;
   gpio_vec_t out_q;
   gpio_vec_t rise_q;
   gpio_vec_t in_sync;
   gpio_vec_t in_rise;
   gpio_vec_t rise_clr;

   edge_sync #(
      .T_PAYLOAD (gpio_vec_t)
   ) i_in_sync (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .async_i (gpio_i),
      .level_o (in_sync),
      .rise_o  (in_rise)
   );

   assign offset = bus_s.paddr[$bits(reg_off_t)-1:0];
   assign wr_en  = bus_s.psel && bus_s.penable && bus_s.pwrite;
   assign wdata  = gpio_vec_t'(bus_s.pwdata);

   assign rise_clr = (wr_en && offset == GPIO_RISE) ? wdata : '0;

   // ----------------------------------------------------------------------
   // Registers
   // ----------------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         dir_q  <= '0;
         out_q  <= '0;
         rise_q <= '0;
      end else begin
         if (wr_en && offset == GPIO_DIR) begin
            dir_q <= wdata;
         end
         if (wr_en && offset == GPIO_OUT) begin
            out_q <= wdata;
         end
         // Set has priority over the write-one clear
         rise_q <= (rise_q & ~rise_clr) | in_rise;
      end
   end

   // Read mux, IN is read-only
   always_comb begin
      case (offset)
         GPIO_DIR:  bus_s.prdata = apb_data_t'(dir_q);
         GPIO_OUT:  bus_s.prdata = apb_data_t'(out_q);
         GPIO_IN:   bus_s.prdata = apb_data_t'(in_sync);
         GPIO_RISE: bus_s.prdata = apb_data_t'(rise_q);
         default:   bus_s.prdata = '0;
      endcase
   end

   // Zero wait states
   assign bus_s.pready  = bus_s.psel && bus_s.penable;
   assign bus_s.pslverr = 1'b0;

   assign gpio_dir_o = dir_q;
   assign gpio_out_o = out_q;
   assign gpio_irq_o = |rise_q;

endmodule

/* apb_soc_control.sv */
/*
 * SoC control: cluster control register and four cache event counters.
 * Counters wrap silently; a write to a counter clears it whatever the data.
 */

`include "apb_soc_macros.svh"

module apb_soc_control (
   input  logic                         clk_i,
   input  logic                         rst_i,
   apb_if.slave                         bus_s,
   input  periph_regs_pkg::llc_events_t llc_events_i,
   output logic                         cluster_rstn_o,
   output logic                         cluster_en_sa_boot_o,
   output logic                         cluster_fetch_en_o
);

   import apb_soc_pkg::*;
   import periph_regs_pkg::*;

   localparam int unsigned NUM_CNT = $bits(llc_events_t);

   typedef logic [`APB_SOC_CNT_W-1:0] cnt_t;

   reg_off_t      offset;
   logic          wr_en;
   cluster_ctrl_t cluster_q;
   cnt_t          cnt_q [NUM_CNT];
   llc_events_t   ev_rise;
   logic [NUM_CNT-1:0] ev_inc;
   logic          cnt_hit;
   logic [$clog2(NUM_CNT)-1:0] cnt_sel;

   edge_sync #(
      .T_PAYLOAD (llc_events_t)
   ) i_ev_sync (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .async_i (llc_events_i),
      .level_o (),
      .rise_o  (ev_rise)
   );

   // One increment per rising edge of an event
   assign ev_inc = ev_rise;

   assign offset = bus_s.paddr[$bits(reg_off_t)-1:0];
   assign wr_en  = bus_s.psel && bus_s.penable && bus_s.pwrite;

   // ----------------------------------------------------------------------
   // Counter select, index follows the event bit order
   // ----------------------------------------------------------------------
   always_comb begin
      cnt_hit = 1'b1;
      case (offset)
         CTRL_READ_HIT:   cnt_sel = 2'd0;
         CTRL_READ_MISS:  cnt_sel = 2'd1;
         CTRL_WRITE_HIT:  cnt_sel = 2'd2;
         CTRL_WRITE_MISS: cnt_sel = 2'd3;
         default: begin
            cnt_hit = 1'b0;
            cnt_sel = 2'd0;
         end
      endcase
   end

   // ----------------------------------------------------------------------
   // Registers
   // ----------------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         cluster_q <= '0;
      end else if (wr_en && offset == CTRL_CLUSTER) begin
         cluster_q <= cluster_ctrl_t'(bus_s.pwdata[$bits(cluster_ctrl_t)-1:0]);
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         for (int i = 0; i < NUM_CNT; i++) begin
            cnt_q[i] <= '0;
         end
      end else begin
         for (int i = 0; i < NUM_CNT; i++) begin
            if (wr_en && cnt_hit && cnt_sel == i) begin
               cnt_q[i] <= '0;
            end else if (ev_inc[i]) begin
               cnt_q[i] <= cnt_q[i] + 1'b1;
            end
         end
      end
   end

   // Read mux
   always_comb begin
      if (offset == CTRL_CLUSTER) begin
         bus_s.prdata = apb_data_t'(cluster_q);
      end else if (cnt_hit) begin
         bus_s.prdata = apb_data_t'(cnt_q[cnt_sel]);
      end else begin
         bus_s.prdata = '0;
      end
   end

   assign bus_s.pready  = bus_s.psel && bus_s.penable;
   assign bus_s.pslverr = 1'b0;

   assign cluster_rstn_o       = cluster_q.rstn;
   assign cluster_en_sa_boot_o = cluster_q.en_sa_boot;
   assign cluster_fetch_en_o   = cluster_q.fetch_en;

endmodule

/* apb_subsystem.sv */
/*
 * APB peripheral subsystem top: one APB slave port, GPIO and SoC control.
 * Single clock domain; every transfer completes in its first access cycle.
 */

`include "apb_soc_macros.svh"

module apb_subsystem (
   input  logic                         clk_i,
   input  logic                         rst_i,

   // APB slave port
   input  logic                         psel_i,
   input  logic                         penable_i,
   input  logic                         pwrite_i,
   input  apb_soc_pkg::apb_addr_t       paddr_i,
   input  apb_soc_pkg::apb_data_t       pwdata_i,
   output apb_soc_pkg::apb_data_t       prdata_o,
   output logic                         pready_o,
   output logic                         pslverr_o,

   // GPIO pins
   input  logic [`APB_SOC_NUM_GPIO-1:0] gpio_i,
   output logic [`APB_SOC_NUM_GPIO-1:0] gpio_out_o,
   output logic [`APB_SOC_NUM_GPIO-1:0] gpio_dir_o,
   output logic                         gpio_irq_o,

   // Last-level-cache events
   input  logic                         llc_read_hit_i,
   input  logic                         llc_read_miss_i,
   input  logic                         llc_write_hit_i,
   input  logic                         llc_write_miss_i,

   // Cluster control
   output logic                         cluster_rstn_o,
   output logic                         cluster_en_sa_boot_o,
   output logic                         cluster_fetch_en_o
);

   import periph_regs_pkg::*;

   llc_events_t llc_events;

   apb_if gpio_bus ();
   apb_if ctrl_bus ();

   assign llc_events.read_hit   = llc_read_hit_i;
   assign llc_events.read_miss  = llc_read_miss_i;
   assign llc_events.write_hit  = llc_write_hit_i;
   assign llc_events.write_miss = llc_write_miss_i;

   apb_periph_demux i_demux (
      .psel_i    (psel_i),
      .penable_i (penable_i),
      .pwrite_i  (pwrite_i),
      .paddr_i   (paddr_i),
      .pwdata_i  (pwdata_i),
      .prdata_o  (prdata_o),
      .pready_o  (pready_o),
      .pslverr_o (pslverr_o),
      .gpio_m    (gpio_bus),
      .ctrl_m    (ctrl_bus)
   );

   apb_gpio i_apb_gpio (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .bus_s      (gpio_bus),
      .gpio_i     (gpio_i),
      .gpio_out_o (gpio_out_o),
      .gpio_dir_o (gpio_dir_o),
      .gpio_irq_o (gpio_irq_o)
   );

   apb_soc_control i_apb_soc_control (
      .clk_i                (clk_i),
      .rst_i                (rst_i),
      .bus_s                (ctrl_bus),
      .llc_events_i         (llc_events),
      .cluster_rstn_o       (cluster_rstn_o),
      .cluster_en_sa_boot_o (cluster_en_sa_boot_o),
      .cluster_fetch_en_o   (cluster_fetch_en_o)
   );

endmodule

/* apb_subsystem_assert.sv */
/*
 * Concurrent APB and reset checks for the subsystem top, attached by bind.
 * Assumes zero wait states, so every access cycle must complete.
 */

`include "apb_soc_macros.svh"

module apb_subsystem_assert (
   input logic                         clk_i,
   input logic                         rst_i,
   input logic                         psel_i,
   input logic                         penable_i,
   input logic                         pwrite_i,
   input apb_soc_pkg::apb_addr_t       paddr_i,
   input apb_soc_pkg::apb_data_t       pwdata_i,
   input logic                         pready_i,
   input logic                         pslverr_i,
   input logic [`APB_SOC_NUM_GPIO-1:0] gpio_out_i,
   input logic [`APB_SOC_NUM_GPIO-1:0] gpio_dir_i,
   input logic                         gpio_irq_i,
   input logic                         cluster_rstn_i,
   input logic                         cluster_boot_i,
   input logic                         cluster_fetch_i
);

   int unsigned fail_cnt = 0;

   // ----------------------------------------------------------------------
   // APB handshake
   // ----------------------------------------------------------------------
   a_setup_to_access: assert property (@(posedge clk_i) disable iff (rst_i)
      psel_i && !penable_i |=> psel_i && penable_i && $stable(paddr_i)
                               && $stable(pwrite_i) && $stable(pwdata_i))
      else begin
         fail_cnt++;
         $error("access phase missing or transfer fields changed after setup");
      end

   a_ready_only_in_access: assert property (@(posedge clk_i) disable iff (rst_i)
      pready_i |-> psel_i && penable_i)
      else begin
         fail_cnt++;
         $error("pready high outside an access cycle");
      end

   a_access_completes: assert property (@(posedge clk_i) disable iff (rst_i)
      psel_i && penable_i |-> pready_i)
      else begin
         fail_cnt++;
         $error("access cycle without pready");
      end

   a_err_with_ready: assert property (@(posedge clk_i) disable iff (rst_i)
      pslverr_i |-> pready_i)
      else begin
         fail_cnt++;
         $error("pslverr high without pready");
      end

   // ----------------------------------------------------------------------
   // Reset state
   // ----------------------------------------------------------------------
   a_reset_bus_idle: assert property (@(posedge clk_i)
      rst_i |-> !pready_i && !pslverr_i)
      else begin
         fail_cnt++;
         $error("bus response active during reset");
      end

   // Also covers the first cycle after reset is released
   a_reset_outputs: assert property (@(posedge clk_i)
      rst_i |=> gpio_dir_i == '0 && gpio_out_i == '0 && !gpio_irq_i
                && !cluster_rstn_i && !cluster_boot_i && !cluster_fetch_i)
      else begin
         fail_cnt++;
         $error("control output not cleared by reset");
      end

endmodule

bind apb_subsystem apb_subsystem_assert u_assert (
   .clk_i           (clk_i),
   .rst_i           (rst_i),
   .psel_i          (psel_i),
   .penable_i       (penable_i),
   .pwrite_i        (pwrite_i),
   .paddr_i         (paddr_i),
   .pwdata_i        (pwdata_i),
   .pready_i        (pready_o),
   .pslverr_i       (pslverr_o),
   .gpio_out_i      (gpio_out_o),
   .gpio_dir_i      (gpio_dir_o),
   .gpio_irq_i      (gpio_irq_o),
   .cluster_rstn_i  (cluster_rstn_o),
   .cluster_boot_i  (cluster_en_sa_boot_o),
   .cluster_fetch_i (cluster_fetch_en_o)
);

/* tb_apb_subsystem.sv */
/*
 * Testbench for the APB peripheral subsystem with fixed-seed random data.
 * Inputs change on the falling edge; responses are taken at the rising edge.
 */

`include "apb_soc_macros.svh"

module tb_apb_subsystem;

   import apb_soc_pkg::*;

   localparam apb_addr_t GPIO     = `APB_SOC_GPIO_BASE;
   localparam apb_addr_t CTRL     = `APB_SOC_CTRL_BASE;
   localparam apb_addr_t UNMAPPED = 32'h1A10_2000;
   localparam int        MAX_WAIT = 20;
   localparam int        MAX_POLL = 50;

   logic        clk;
   logic        rst;
   logic        psel;
   logic        penable;
   logic        pwrite;
   apb_addr_t   paddr;
   apb_data_t   pwdata;
   apb_data_t   prdata;
   logic        pready;
   logic        pslverr;
   logic [31:0] gpio_in;
   logic [31:0] gpio_out;
   logic [31:0] gpio_dir;
   logic        gpio_irq;
   logic [3:0]  llc_ev;
   logic        cluster_rstn;
   logic        cluster_boot;
   logic        cluster_fetch;
   int          errors = 0;
   int          timeouts = 0;

   apb_subsystem uut (
      .clk_i (clk), .rst_i (rst),
      .psel_i (psel), .penable_i (penable), .pwrite_i (pwrite),
      .paddr_i (paddr), .pwdata_i (pwdata), .prdata_o (prdata),
      .pready_o (pready), .pslverr_o (pslverr),
      .gpio_i (gpio_in), .gpio_out_o (gpio_out), .gpio_dir_o (gpio_dir),
      .gpio_irq_o (gpio_irq),
      .llc_read_hit_i (llc_ev[0]), .llc_read_miss_i (llc_ev[1]),
      .llc_write_hit_i (llc_ev[2]), .llc_write_miss_i (llc_ev[3]),
      .cluster_rstn_o (cluster_rstn), .cluster_en_sa_boot_o (cluster_boot),
      .cluster_fetch_en_o (cluster_fetch)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic expect_eq(input string name, input apb_data_t exp, input apb_data_t act);
      assert (act === exp) else begin
         errors++;
         $display("error %s: expected 0x%08h, actual 0x%08h", name, exp, act);
      end
   endtask

   // ----------------------------------------------------------------------
   // APB master
   // ----------------------------------------------------------------------
   task automatic run_transfer(input string name, input logic wr, input apb_addr_t addr,
                               input apb_data_t wdata, output apb_data_t rdata,
                               output logic err);
      int waited;
      waited = 0;
      rdata = '0;
      err = 1'b0;
      @(negedge clk);
      psel = 1'b1;
      penable = 1'b0;
      pwrite = wr;
      paddr = addr;
      pwdata = wdata;
      @(negedge clk);
      penable = 1'b1;
      @(posedge clk);
      while (!pready && waited < MAX_WAIT) begin
         @(posedge clk);
         waited++;
      end
      if (pready) begin
         rdata = prdata;
         err = pslverr;
      end else begin
         timeouts++;
         $display("timeout: %s got no pready", name);
      end
      @(negedge clk);
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
   endtask

   task automatic write_reg(input string name, input apb_addr_t addr, input apb_data_t data,
                            input logic exp_err);
      apb_data_t rdata;
      logic err;
      run_transfer(name, 1'b1, addr, data, rdata, err);
      expect_eq({name, " pslverr"}, 32'(exp_err), 32'(err));
   endtask

   task automatic read_reg(input string name, input apb_addr_t addr, input apb_data_t exp,
                           input logic exp_err);
      apb_data_t rdata;
      logic err;
      run_transfer(name, 1'b0, addr, '0, rdata, err);
      expect_eq(name, exp, rdata);
      expect_eq({name, " pslverr"}, 32'(exp_err), 32'(err));
   endtask

   // Reads until the value shows up or the poll budget runs out
   task automatic poll_reg(input string name, input apb_addr_t addr, input apb_data_t exp);
      apb_data_t rdata;
      logic err;
      int polls;
      polls = 0;
      rdata = ~exp;
      while (rdata !== exp && polls < MAX_POLL) begin
         run_transfer(name, 1'b0, addr, '0, rdata, err);
         polls++;
      end
      if (rdata !== exp) begin
         timeouts++;
         $display("timeout: %s never read back 0x%08h", name, exp);
      end
   endtask

   initial begin
      apb_data_t dir_val;
      apb_data_t out_val;
      apb_data_t in_val;
      apb_data_t rdata;
      logic err;
      logic [2:0] cl_val;
      int pulses [4];
      int k;
      void'($urandom(31698));
      rst = 1'b1;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
      paddr = '0;
      pwdata = '0;
      gpio_in = '0;
      llc_ev = '0;
      repeat (16) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      // Reset state
      expect_eq("reset gpio_dir_o", '0, gpio_dir);
      expect_eq("reset gpio_out_o", '0, gpio_out);
      expect_eq("reset irq and cluster", '0,
                32'({gpio_irq, cluster_fetch, cluster_boot, cluster_rstn}));
      for (int i = 0; i < 4; i++) begin
         read_reg($sformatf("reset gpio 0x%0h", 4 * i), GPIO + 32'(4 * i), '0, 1'b0);
         read_reg($sformatf("reset counter %0d", i), CTRL + 32'h10 + 32'(4 * i), '0, 1'b0);
      end
      read_reg("reset cluster", CTRL, '0, 1'b0);

      // GPIO outputs, IN ignores writes
      dir_val = $urandom;
      out_val = $urandom;
      write_reg("write dir", GPIO + 32'h0, dir_val, 1'b0);
      write_reg("write out", GPIO + 32'h4, out_val, 1'b0);
      expect_eq("gpio_dir_o", dir_val, gpio_dir);
      expect_eq("gpio_out_o", out_val, gpio_out);
      read_reg("read dir", GPIO + 32'h0, dir_val, 1'b0);
      read_reg("read out", GPIO + 32'h4, out_val, 1'b0);
      write_reg("write in", GPIO + 32'h8, $urandom, 1'b0);
      read_reg("read in after write", GPIO + 32'h8, '0, 1'b0);

      // Inputs and sticky rise status
      in_val = $urandom | 32'h1;
      @(negedge clk);
      gpio_in = in_val;
      poll_reg("poll in", GPIO + 32'h8, in_val);
      read_reg("rise set", GPIO + 32'hC, in_val, 1'b0);
      expect_eq("gpio_irq_o set", 32'h1, 32'(gpio_irq));
      write_reg("clear rise", GPIO + 32'hC, in_val, 1'b0);
      read_reg("rise cleared", GPIO + 32'hC, '0, 1'b0);
      expect_eq("gpio_irq_o cleared", '0, 32'(gpio_irq));

      // Cluster control, rstn in bit 0
      cl_val = 3'($urandom);
      write_reg("write cluster", CTRL, {29'($urandom), cl_val}, 1'b0);
      expect_eq("cluster outputs", 32'(cl_val),
                32'({cluster_fetch, cluster_boot, cluster_rstn}));
      read_reg("read cluster", CTRL, 32'(cl_val), 1'b0);

      // ----------------------------------------------------------------------
      // Event counters, 3 cycles high and 3 low per pulse
      // ----------------------------------------------------------------------
      for (int i = 0; i < 4; i++) begin
         pulses[i] = 1 + int'($urandom % 10);
      end
      for (int p = 0; p < 10; p++) begin
         @(negedge clk);
         for (int i = 0; i < 4; i++) begin
            llc_ev[i] = (p < pulses[i]);
         end
         repeat (3) @(negedge clk);
         llc_ev = '0;
         repeat (2) @(negedge clk);
      end
      for (int i = 0; i < 4; i++) begin
         poll_reg($sformatf("poll counter %0d", i), CTRL + 32'h10 + 32'(4 * i),
                  32'(pulses[i]));
         read_reg($sformatf("counter %0d", i), CTRL + 32'h10 + 32'(4 * i),
                  32'(pulses[i]), 1'b0);
      end
      k = int'($urandom % 4);
      write_reg("clear counter", CTRL + 32'h10 + 32'(4 * k), $urandom, 1'b0);
      for (int i = 0; i < 4; i++) begin
         read_reg($sformatf("counter %0d after clear", i), CTRL + 32'h10 + 32'(4 * i),
                  (i == k) ? '0 : 32'(pulses[i]), 1'b0);
      end

      // Unmapped address
      read_reg("unmapped read", UNMAPPED, '0, 1'b1);
      run_transfer("unmapped write", 1'b1, UNMAPPED, $urandom, rdata, err);
      expect_eq("unmapped write pslverr", 32'h1, 32'(err));
      expect_eq("unmapped write prdata", '0, rdata);
      read_reg("dir kept", GPIO + 32'h0, dir_val, 1'b0);
      read_reg("out kept", GPIO + 32'h4, out_val, 1'b0);
      read_reg("cluster kept", CTRL, 32'(cl_val), 1'b0);

      $display("checks done: %0d errors, %0d timeouts, %0d assertion failures",
               errors, timeouts, uut.u_assert.fail_cnt);
      if (errors == 0 && timeouts == 0 && uut.u_assert.fail_cnt == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

/* sources.f */
+incdir+.
apb_soc_pkg.sv
periph_regs_pkg.sv
apb_if.sv
edge_sync.sv
apb_periph_demux.sv
apb_gpio.sv
apb_soc_control.sv
apb_subsystem.sv
apb_subsystem_assert.sv
tb_apb_subsystem.sv
